/* rtl/fifo_probe_config.svh */
`ifndef FIFO_PROBE_CONFIG_SVH
`define FIFO_PROBE_CONFIG_SVH

// stream word layout
`define FP_DATA_WIDTH 16
`define FP_USER_WIDTH 4

`define FP_FIFO_DEPTH 8     // power of two, at least 2
`define FP_ADDR_WIDTH 16    // AXI-lite byte address

`define FP_VERSION 32'h0001_0069
`define FP_MAGIC 32'h4649_464F  // "FIFO"

`endif

/* rtl/fifo_probe_pkg.sv */
`include "fifo_probe_config.svh"

package fifo_probe_pkg;

    // word addresses, byte offset already dropped
    typedef enum logic [2:0] {
        REG_VERSION = 3'd0,
        REG_ID      = 3'd1,
        REG_CTRL    = 3'd2,
        REG_MAGIC   = 3'd3,
        REG_DEPTH   = 3'd4,
        REG_LEVEL   = 3'd5,
        REG_EMPTY   = 3'd6,
        REG_POP     = 3'd7
    } reg_addr_e;

    typedef struct packed {
        logic [32 - `FP_DATA_WIDTH - `FP_USER_WIDTH - 3:0] pad;
        logic                                              empty;
        logic                                              last;
        logic [`FP_USER_WIDTH - 1:0]                       user;
        logic [`FP_DATA_WIDTH - 1:0]                       data;
    } pop_fields_t;

    typedef union packed {
        logic [31:0] raw;
        pop_fields_t fields;
    } pop_word_t;

endpackage

/* rtl/reg_bus_if.sv */
`timescale 1ns/1ns
`include "fifo_probe_config.svh"

interface reg_bus_if #(
    parameter int AW = `FP_ADDR_WIDTH - 2  // word address
);
    logic          rreq;
    logic [AW-1:0] raddr;
    logic [31:0]   rdata;
    logic          rack;

    logic          wreq;
    logic [AW-1:0] waddr;
    logic [31:0]   wdata;
    logic          wack;

    modport host (
        output rreq, raddr, wreq, waddr, wdata,
        input  rdata, rack, wack
    );

    modport regs (
        input  rreq, raddr, wreq, waddr, wdata,
        output rdata, rack, wack
    );

endinterface

/* rtl/stream_fifo.sv */
`timescale 1ns/1ns
`include "fifo_probe_config.svh"

module stream_fifo #(
    parameter int DEPTH      = `FP_FIFO_DEPTH,
    parameter int DATA_WIDTH = `FP_DATA_WIDTH,
    parameter int USER_WIDTH = `FP_USER_WIDTH,
    localparam int PTR_W     = $clog2(DEPTH)
) (
    input  logic                  clk_i,
    input  logic                  reset_ni,

    input  logic [DATA_WIDTH-1:0] wr_data_i,
    input  logic [USER_WIDTH-1:0] wr_user_i,
    input  logic                  wr_last_i,
    input  logic                  wr_valid_i,
    output logic                  full_o,

    input  logic                  pop_i,
    input  logic                  flush_i,

    output logic [DATA_WIDTH-1:0] head_data_o,
    output logic [USER_WIDTH-1:0] head_user_o,
    output logic                  head_last_o,
    output logic                  empty_o,
    output logic [PTR_W:0]        level_o
);

    localparam int ENTRY_W = DATA_WIDTH + USER_WIDTH + 1;

    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [PTR_W:0]     wr_ptr;
    logic [PTR_W:0]     rd_ptr;
    logic               push;
    logic               pull;

    // extra msb tells full from empty
    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                     (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign level_o = wr_ptr - rd_ptr;

    assign push = wr_valid_i && !full_o;
    assign pull = pop_i && !empty_o;   // pop on empty is ignored

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr[PTR_W-1:0]] <= {wr_last_i, wr_user_i, wr_data_i};
        end
    end

    // first word fall through
    assign {head_last_o, head_user_o, head_data_o} = mem[rd_ptr[PTR_W-1:0]];

endmodule

/* rtl/axil_slave.sv */
`timescale 1ns/1ns
`include "fifo_probe_config.svh"

module axil_slave (
    input  logic                      clk_i,
    input  logic                      reset_ni,

    input  logic [`FP_ADDR_WIDTH-1:0] awaddr_i,
    input  logic                      awvalid_i,
    output logic                      awready_o,

    input  logic [31:0]               wdata_i,
    input  logic                      wvalid_i,
    output logic                      wready_o,

    output logic [1:0]                bresp_o,
    output logic                      bvalid_o,
    input  logic                      bready_i,

    input  logic [`FP_ADDR_WIDTH-1:0] araddr_i,
    input  logic                      arvalid_i,
    output logic                      arready_o,

    output logic [31:0]               rdata_o,
    output logic [1:0]                rresp_o,
    output logic                      rvalid_o,
    input  logic                      rready_i,

    reg_bus_if.host                   bus
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {R_IDLE, R_WAIT, R_RESP} r_state_e;
    typedef enum logic [1:0] {W_IDLE, W_WAIT, W_RESP} w_state_e;

    r_state_e r_state;
    w_state_e w_state;
    logic     aw_got;
    logic     w_got;
    logic     aw_hs;
    logic     w_hs;
    logic     bus_idle;

    assign bresp_o = RESP_OKAY;
    assign rresp_o = RESP_OKAY;

    assign bus_idle  = (r_state == R_IDLE) && (w_state == W_IDLE);
    assign arready_o = bus_idle;
    // read wins when both directions show up together
    assign awready_o = bus_idle && !arvalid_i && !aw_got;
    assign wready_o  = bus_idle && !arvalid_i && !w_got;

    assign aw_hs = awvalid_i && awready_o;
    assign w_hs  = wvalid_i && wready_o;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            r_state  <= R_IDLE;
            bus.rreq <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            bus.rreq <= 1'b0;   // single cycle pulse
            case (r_state)
                R_IDLE: if (arvalid_i && arready_o) begin
                    bus.raddr <= araddr_i[`FP_ADDR_WIDTH-1:2];
                    bus.rreq  <= 1'b1;
                    r_state   <= R_WAIT;
                end
                R_WAIT: if (bus.rack) begin
                    rdata_o  <= bus.rdata;
                    rvalid_o <= 1'b1;
                    r_state  <= R_RESP;
                end
                default: if (rready_i) begin
                    rvalid_o <= 1'b0;
                    r_state  <= R_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            w_state  <= W_IDLE;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            bus.wreq <= 1'b0;
            bvalid_o <= 1'b0;
        end else begin
            bus.wreq <= 1'b0;
            case (w_state)
                W_IDLE: begin
                    if (aw_hs) begin
                        bus.waddr <= awaddr_i[`FP_ADDR_WIDTH-1:2];
                        aw_got    <= 1'b1;
                    end
                    if (w_hs) begin
                        bus.wdata <= wdata_i;
                        w_got     <= 1'b1;
                    end
                    // both halves in, fire the request
                    if ((aw_got || aw_hs) && (w_got || w_hs)) begin
                        aw_got   <= 1'b0;
                        w_got    <= 1'b0;
                        bus.wreq <= 1'b1;
                        w_state  <= W_WAIT;
                    end
                end
                W_WAIT: if (bus.wack) begin
                    bvalid_o <= 1'b1;
                    w_state  <= W_RESP;
                end
                default: if (bready_i) begin
                    bvalid_o <= 1'b0;
                    w_state  <= W_IDLE;
                end
            endcase
        end
    end

endmodule

/* rtl/fifo_reg_file.sv */
`timescale 1ns/1ns
`include "fifo_probe_config.svh"

module fifo_reg_file #(
    parameter logic [31:0] ID = 32'h0,
    localparam int LEVEL_W    = $clog2(`FP_FIFO_DEPTH) + 1
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,

    reg_bus_if.regs                   bus,

    output logic                      pop_o,
    output logic                      flush_o,
    input  logic [`FP_DATA_WIDTH-1:0] head_data_i,
    input  logic [`FP_USER_WIDTH-1:0] head_user_i,
    input  logic                      head_last_i,
    input  logic                      empty_i,
    input  logic [LEVEL_W-1:0]        level_i
);

    import fifo_probe_pkg::*;

    localparam int WAW = `FP_ADDR_WIDTH - 2;

    pop_word_t pop_word;
    reg_addr_e rd_reg;
    logic      rd_in_range;
    logic      wr_ctrl;

    assign rd_reg      = reg_addr_e'(bus.raddr[2:0]);
    assign rd_in_range = (bus.raddr[WAW-1:3] == '0);   // above 7 reads zero
    assign wr_ctrl     = (bus.waddr == WAW'(REG_CTRL));

    always_comb begin
        pop_word.raw = '0;
        pop_word.fields.empty = empty_i;
        if (!empty_i) begin
            pop_word.fields.last = head_last_i;
            pop_word.fields.user = head_user_i;
            pop_word.fields.data = head_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            bus.rack <= 1'b0;
            bus.wack <= 1'b0;
            pop_o    <= 1'b0;
            flush_o  <= 1'b0;
        end else begin
            bus.rack <= bus.rreq;
            bus.wack <= bus.wreq;
            // head already latched, pop lands with the ack
            pop_o    <= bus.rreq && rd_in_range && (rd_reg == REG_POP) && !empty_i;
            flush_o  <= bus.wreq && wr_ctrl && bus.wdata[0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus.rreq) begin
            if (!rd_in_range) begin
                bus.rdata <= '0;
            end else begin
                case (rd_reg)
                    REG_VERSION: bus.rdata <= `FP_VERSION;
                    REG_ID:      bus.rdata <= ID;
                    REG_MAGIC:   bus.rdata <= `FP_MAGIC;
                    REG_DEPTH:   bus.rdata <= 32'(`FP_FIFO_DEPTH);
                    REG_LEVEL:   bus.rdata <= 32'(level_i);
                    REG_EMPTY:   bus.rdata <= {31'b0, empty_i};
                    REG_POP:     bus.rdata <= pop_word.raw;
                    default:     bus.rdata <= '0;   // ctrl is write only
                endcase
            end
        end
    end

endmodule

/* rtl/fifo_probe_top.sv */
`timescale 1ns/1ns
`include "fifo_probe_config.svh"

module fifo_probe_top #(
    parameter logic [31:0] ID = 32'h0
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,

    input  logic [`FP_DATA_WIDTH-1:0] in_data_i,
    input  logic [`FP_USER_WIDTH-1:0] in_user_i,
    input  logic                      in_last_i,
    input  logic                      in_valid_i,
    output logic                      in_full_o,

    input  logic [`FP_ADDR_WIDTH-1:0] awaddr_i,
    input  logic                      awvalid_i,
    output logic                      awready_o,
    input  logic [31:0]               wdata_i,
    input  logic                      wvalid_i,
    output logic                      wready_o,
    output logic [1:0]                bresp_o,
    output logic                      bvalid_o,
    input  logic                      bready_i,
    input  logic [`FP_ADDR_WIDTH-1:0] araddr_i,
    input  logic                      arvalid_i,
    output logic                      arready_o,
    output logic [31:0]               rdata_o,
    output logic [1:0]                rresp_o,
    output logic                      rvalid_o,
    input  logic                      rready_i
);

    localparam int LEVEL_W = $clog2(`FP_FIFO_DEPTH) + 1;

    logic                      fifo_pop;
    logic                      fifo_flush;
    logic [`FP_DATA_WIDTH-1:0] head_data;
    logic [`FP_USER_WIDTH-1:0] head_user;
    logic                      head_last;
    logic                      fifo_empty;
    logic [LEVEL_W-1:0]        fifo_level;

    reg_bus_if reg_bus ();

    stream_fifo fifo_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .wr_data_i   (in_data_i),
        .wr_user_i   (in_user_i),
        .wr_last_i   (in_last_i),
        .wr_valid_i  (in_valid_i),
        .full_o      (in_full_o),
        .pop_i       (fifo_pop),
        .flush_i     (fifo_flush),
        .head_data_o (head_data),
        .head_user_o (head_user),
        .head_last_o (head_last),
        .empty_o     (fifo_empty),
        .level_o     (fifo_level)
    );

    axil_slave axil_i (
        .clk_i     (clk_i),
        .reset_ni  (reset_ni),
        .awaddr_i  (awaddr_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .araddr_i  (araddr_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .bus       (reg_bus.host)
    );

    fifo_reg_file #(
        .ID (ID)
    ) regs_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .bus         (reg_bus.regs),
        .pop_o       (fifo_pop),
        .flush_o     (fifo_flush),
        .head_data_i (head_data),
        .head_user_i (head_user),
        .head_last_i (head_last),
        .empty_i     (fifo_empty),
        .level_i     (fifo_level)
    );

endmodule

/* bench/fifo_probe_assert.sv */
`timescale 1ns/1ns
`include "fifo_probe_config.svh"

module fifo_probe_assert #(
    parameter int LEVEL_W = $clog2(`FP_FIFO_DEPTH) + 1
) (
    input logic               clk_i,
    input logic               reset_ni,
    input logic               arvalid_i,
    input logic               arready_i,
    input logic               awvalid_i,
    input logic               awready_i,
    input logic               wvalid_i,
    input logic               wready_i,
    input logic               rvalid_i,
    input logic               rready_i,
    input logic [31:0]        rdata_i,
    input logic               bvalid_i,
    input logic               bready_i,
    input logic               in_full_i,
    input logic [LEVEL_W-1:0] level_i
);

    // valid holds until its ready
    ar_hold: assert property (@(posedge clk_i) disable iff (!reset_ni)
        arvalid_i && !arready_i |=> arvalid_i)
        else $error("arvalid dropped before arready");
    aw_hold: assert property (@(posedge clk_i) disable iff (!reset_ni)
        awvalid_i && !awready_i |=> awvalid_i)
        else $error("awvalid dropped before awready");
    w_hold: assert property (@(posedge clk_i) disable iff (!reset_ni)
        wvalid_i && !wready_i |=> wvalid_i)
        else $error("wvalid dropped before wready");
    r_hold: assert property (@(posedge clk_i) disable iff (!reset_ni)
        rvalid_i && !rready_i |=> rvalid_i)
        else $error("rvalid dropped before rready");
    b_hold: assert property (@(posedge clk_i) disable iff (!reset_ni)
        bvalid_i && !bready_i |=> bvalid_i)
        else $error("bvalid dropped before bready");

    r_stable: assert property (@(posedge clk_i) disable iff (!reset_ni)
        rvalid_i && !rready_i |=> $stable(rdata_i))
        else $error("rdata changed while waiting for rready");

    full_level: assert property (@(posedge clk_i) disable iff (!reset_ni)
        in_full_i |-> level_i == LEVEL_W'(`FP_FIFO_DEPTH))
        else $error("in_full_o high with level below depth");

endmodule

bind fifo_probe_top fifo_probe_assert assert_i (
    .clk_i     (clk_i),
    .reset_ni  (reset_ni),
    .arvalid_i (arvalid_i),
    .arready_i (arready_o),
    .awvalid_i (awvalid_i),
    .awready_i (awready_o),
    .wvalid_i  (wvalid_i),
    .wready_i  (wready_o),
    .rvalid_i  (rvalid_o),
    .rready_i  (rready_i),
    .rdata_i   (rdata_o),
    .bvalid_i  (bvalid_o),
    .bready_i  (bready_i),
    .in_full_i (in_full_o),
    .level_i   (fifo_level)
);

/* bench/fifo_probe_tb.sv */
`timescale 1ns/1ns
`include "fifo_probe_config.svh"

module fifo_probe_tb;

    import fifo_probe_pkg::*;

    localparam int DEPTH   = `FP_FIFO_DEPTH;
    localparam int TIMEOUT = 50;   // cycles per wait
    localparam int AW      = `FP_ADDR_WIDTH;

    logic                      clk_i;
    logic                      reset_ni;
    logic [`FP_DATA_WIDTH-1:0] in_data;
    logic [`FP_USER_WIDTH-1:0] in_user;
    logic                      in_last;
    logic                      in_valid;
    logic                      in_full;
    logic [AW-1:0]             awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [31:0]               wdata;
    logic                      wvalid;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      bready;
    logic [AW-1:0]             araddr;
    logic                      arvalid;
    logic                      arready;
    logic [31:0]               rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
    logic                      rready;

    integer seed;
    int     checks;
    int     errors;
    int     timeouts;
    string  test_name;

    fifo_probe_top #(
        .ID (32'h2A)
    ) dut_i (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .in_data_i  (in_data),
        .in_user_i  (in_user),
        .in_last_i  (in_last),
        .in_valid_i (in_valid),
        .in_full_o  (in_full),
        .awaddr_i   (awaddr),
        .awvalid_i  (awvalid),
        .awready_o  (awready),
        .wdata_i    (wdata),
        .wvalid_i   (wvalid),
        .wready_o   (wready),
        .bresp_o    (bresp),
        .bvalid_o   (bvalid),
        .bready_i   (bready),
        .araddr_i   (araddr),
        .arvalid_i  (arvalid),
        .arready_o  (arready),
        .rdata_o    (rdata),
        .rresp_o    (rresp),
        .rvalid_o   (rvalid),
        .rready_i   (rready)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // last line of defence if a wait loop is ever broken
    initial begin
        #200000;
        $display("simulation ran too long and was stopped");
        $display("Test failed");
        $finish;
    end

    function automatic logic [AW-1:0] reg_byte_addr(input int word_addr);
        return AW'(word_addr * 4);
    endfunction

    task automatic note_timeout(input string what);
        timeouts++;
        $display("timeout in %s: no %s within %0d cycles", test_name, what, TIMEOUT);
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_resp(input string name, input logic [1:0] exp,
                                input logic [1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected resp %b, actual resp %b", name, exp, act);
        end
    endtask

    task automatic compare_pop(input string name, input pop_word_t exp, input pop_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h (empty %0b last %0b user %h data %h), %s",
                     name, exp.raw, exp.fields.empty, exp.fields.last, exp.fields.user,
                     exp.fields.data,
                     $sformatf("actual %h (empty %0b last %0b user %h data %h)",
                               act.raw, act.fields.empty, act.fields.last,
                               act.fields.user, act.fields.data));
        end
    endtask

    // all bus tasks start and end 2 ns after a rising edge
    task automatic axil_read(input logic [AW-1:0] addr, output logic [31:0] data);
        int n;
        data    = '0;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b0;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk_i);
            if (arready) break;
        end
        if (n == TIMEOUT) note_timeout("arready");
        @(posedge clk_i);
        #2 arvalid = 1'b0;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk_i);
            if (rvalid) break;
        end
        if (n == TIMEOUT) begin
            note_timeout("rvalid");
        end else begin
            @(posedge clk_i);   // late rready makes rvalid and rdata hold
            #2 rready = 1'b1;
            @(negedge clk_i);
            data = rdata;
            compare_resp(test_name, 2'b00, rresp);
        end
        @(posedge clk_i);
        #2 rready = 1'b0;
    endtask

    task automatic axil_write(input logic [AW-1:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int n;
        resp    = 2'b11;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk_i);
            if (awready && wready) break;
        end
        if (n == TIMEOUT) note_timeout("awready and wready");
        @(posedge clk_i);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk_i);
            if (bvalid) break;
        end
        if (n == TIMEOUT) begin
            note_timeout("bvalid");
        end else begin
            @(posedge clk_i);   // bvalid waits a cycle for bready
            #2 bready = 1'b1;
            @(negedge clk_i);
            resp = bresp;
        end
        @(posedge clk_i);
        #2 bready = 1'b0;
    endtask

    task automatic stream_push(input logic [`FP_DATA_WIDTH-1:0] data,
                               input logic [`FP_USER_WIDTH-1:0] user,
                               input logic last, output logic accepted);
        in_data  = data;
        in_user  = user;
        in_last  = last;
        in_valid = 1'b1;
        @(negedge clk_i);
        accepted = !in_full;   // taken at the coming edge
        @(posedge clk_i);
        #2 in_valid = 1'b0;
    endtask

    task automatic push_random(output pop_word_t entry, output logic accepted);
        entry.raw         = '0;
        entry.fields.data = `FP_DATA_WIDTH'($random(seed));
        entry.fields.user = `FP_USER_WIDTH'($random(seed));
        entry.fields.last = 1'($random(seed));
        stream_push(entry.fields.data, entry.fields.user, entry.fields.last, accepted);
    endtask

    task automatic read_check(input int word_addr, input logic [31:0] exp);
        logic [31:0] word;
        axil_read(reg_byte_addr(word_addr), word);
        compare_word(test_name, exp, word);
    endtask

    task automatic pop_check(input pop_word_t exp);
        pop_word_t act;
        axil_read(reg_byte_addr(REG_POP), act.raw);
        compare_pop(test_name, exp, act);
    endtask

    task automatic test_ident();
        test_name = "ident";
        read_check(REG_VERSION, `FP_VERSION);
        read_check(REG_ID, 32'h2A);
        read_check(REG_MAGIC, `FP_MAGIC);
        read_check(REG_DEPTH, 32'(DEPTH));
        read_check(12, 32'h0);   // beyond the map
        read_check(REG_CTRL, 32'h0);
    endtask

    task automatic test_push_pop();
        pop_word_t entry [3];
        logic      ok;
        test_name = "push_pop";
        for (int i = 0; i < 3; i++) begin
            push_random(entry[i], ok);
            compare_word(test_name, 32'd1, 32'(ok));
        end
        read_check(REG_LEVEL, 32'd3);
        read_check(REG_EMPTY, 32'd0);
        for (int i = 0; i < 3; i++) pop_check(entry[i]);
        read_check(REG_EMPTY, 32'd1);
    endtask

    task automatic test_empty_pop();
        pop_word_t exp;
        test_name = "empty_pop";
        exp.raw          = '0;
        exp.fields.empty = 1'b1;
        pop_check(exp);
        read_check(REG_LEVEL, 32'd0);
    endtask

    task automatic test_overflow();
        pop_word_t entry;
        pop_word_t kept [$];
        logic      ok;
        test_name = "overflow";
        for (int i = 0; i < DEPTH + 2; i++) begin
            push_random(entry, ok);
            compare_word(test_name, 32'(i < DEPTH), 32'(ok));
            if (i < DEPTH) kept.push_back(entry);
        end
        compare_word(test_name, 32'd1, 32'(in_full));
        read_check(REG_LEVEL, 32'(DEPTH));
        foreach (kept[i]) pop_check(kept[i]);
        read_check(REG_EMPTY, 32'd1);
    endtask

    task automatic test_flush();
        pop_word_t  entry;
        logic       ok;
        logic [1:0] resp;
        test_name = "flush";
        repeat (3) push_random(entry, ok);
        read_check(REG_LEVEL, 32'd3);
        axil_write(reg_byte_addr(REG_CTRL), 32'd1, resp);
        compare_resp(test_name, 2'b00, resp);
        read_check(REG_LEVEL, 32'd0);
        read_check(REG_EMPTY, 32'd1);
    endtask

    initial begin
        seed     = 71191;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        reset_ni = 1'b0;
        in_data  = '0;
        in_user  = '0;
        in_last  = 1'b0;
        in_valid = 1'b0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        repeat (4) @(posedge clk_i);
        #2 reset_ni = 1'b1;

        test_ident();
        test_push_pop();
        test_empty_pop();
        test_overflow();
        test_flush();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+rtl
rtl/fifo_probe_pkg.sv
rtl/reg_bus_if.sv
rtl/stream_fifo.sv
rtl/axil_slave.sv
rtl/fifo_reg_file.sv
rtl/fifo_probe_top.sv
bench/fifo_probe_assert.sv
bench/fifo_probe_tb.sv

/* Makefile */
TOOL    = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = fifo_probe_tb
FLIST   = flist.f
OBJ_DIR = obj_dir
LOG     = sim.log
PASS    = Test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
